//--- filelist.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/forwarding_unit.sv
verilog/alu.sv
verilog/branch_controller.sv
verilog/execute_stage.sv
verilog/cpu_core.sv
tests/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
# Compile and run the cpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_core \
    -f filelist.f -o sim_cpu_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_cpu_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- tests/tb_cpu_core.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module tb_cpu_core
    import cpu_pkg::*;
();

    logic                 clk;
    logic                 rst_n;
    logic [`CPU_XLEN-1:0] imem_addr;
    instr_t               imem_data;
    logic [`CPU_XLEN-1:0] in_port;
    logic [`CPU_XLEN-1:0] out_port;
    logic                 out_valid;

    logic [15:0] imem [256];
    logic [15:0] prog [$];
    logic [15:0] exp_q [$];    // Expected out_port values in order
    int          errors;
    int          reset_edges;
    int          cycles;

    cpu_core i_dut (.*);

    assign imem_data = imem[imem_addr[7:0]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) reset_edges <= rst_n ? 0 : reset_edges + 1;

    // Outputs only move on the rising edge
    always @(negedge clk) begin
        if (!rst_n && reset_edges > 0) begin
            a_reset_pc: assert (imem_addr == `CPU_PC_RESET) else begin
                errors++;
                $display("Fail imem_addr: expected %h, actual %h", `CPU_PC_RESET, imem_addr);
            end
            a_reset_out: assert (!out_valid) else begin
                errors++;
                $display("out_valid was high while reset was held");
            end
        end else if (rst_n && out_valid) begin
            a_out_expected: assert (exp_q.size() > 0) else begin
                errors++;
                $display("out_valid pulsed after every expected output was already seen");
            end
            if (exp_q.size() > 0) begin
                a_out_port: assert (out_port == exp_q[0]) else begin
                    errors++;
                    $display("Fail out_port: expected %h, actual %h", exp_q[0], out_port);
                end
                void'(exp_q.pop_front());
            end
        end
    end

    task automatic emit_r(logic [3:0] op, int rd = 0, int rs = 0, int sh = 0);
        prog.push_back({op, rd[2:0], rs[2:0], sh[3:0], 2'b00});
    endtask

    task automatic emit_ldm(int rd, int imm);
        prog.push_back({`OP_LDM, rd[2:0], imm[8:0]});
    endtask

    // Jump through r6 over two OUTs
    task automatic jump_over(logic [3:0] op, int rout);
        emit_ldm(6, prog.size() + 4);
        emit_r(op, 6);
        emit_r(`OP_OUT, rout);
        emit_r(`OP_OUT, rout);
    endtask

    // Instruction-level model, no pipeline
    task automatic run_model();
        logic [15:0] r [8];
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        logic [16:0] wide;      // Carry on top of the result
        logic [3:0]  sh;
        logic        c;
        logic        n;
        logic        z;
        logic        taken;
        int          pc;
        int          steps;
        bit          done;
        foreach (r[i]) r[i] = '0;
        {c, n, z} = 3'b000;
        pc = 0;
        done = 0;
        for (steps = 0; steps < 2000 && !done && pc < prog.size(); steps++) begin
            w  = prog[pc];
            a  = r[w[11:9]];
            b  = r[w[8:6]];
            sh = w[5:2];
            pc++;
            if (w[15:12] >= `OP_ADD && w[15:12] <= `OP_SHR) begin
                case (w[15:12])
                    `OP_ADD: wide = {1'b0, a} + {1'b0, b};
                    `OP_SUB: wide = {1'b0, a} + {1'b0, ~b} + 17'd1;   // Carry out is no borrow
                    `OP_AND: wide = {c, a & b};
                    `OP_OR:  wide = {c, a | b};
                    `OP_NOT: wide = {c, ~a};
                    `OP_SHL: wide = (sh == 0) ? {c, a} : {a[16 - sh], a << sh};
                    default: wide = (sh == 0) ? {c, a} : {a[sh - 1], a >> sh};
                endcase
                r[w[11:9]] = wide[15:0];
                {c, n, z} = {wide[16], wide[15], wide[15:0] == 16'd0};
            end else begin
                taken = (w[15:12] == `OP_JMP) || (w[15:12] == `OP_JZ && z) ||
                        (w[15:12] == `OP_JC && c);
                case (w[15:12])
                    `OP_MOV:  r[w[11:9]] = b;
                    `OP_LDM:  r[w[11:9]] = {{7{w[8]}}, w[8:0]};
                    `OP_SETC: c = 1'b1;
                    `OP_OUT:  exp_q.push_back(a);
                    `OP_IN:   r[w[11:9]] = in_port;
                    default:  ;
                endcase
                if (taken) begin
                    done = (int'(a) == pc - 1);     // Self-jump ends the program
                    pc   = int'(a);
                end
            end
        end
    endtask

    initial begin
        logic [3:0] op;
        int         k;
        void'($urandom(32'h56d5));
        rst_n   = 1'b0;
        in_port = 16'($urandom);
        errors  = 0;

        // Dependency chain, immediates and the input port
        emit_ldm(1, 100);
        emit_ldm(2, -7);
        emit_r(`OP_ADD, 1, 2);
        emit_r(`OP_OUT, 1);
        emit_r(`OP_SUB, 2, 1);
        emit_r(`OP_OUT, 2);
        emit_r(`OP_AND, 1, 2);
        emit_r(`OP_OR, 1, 2);
        emit_r(`OP_OUT, 1);
        emit_r(`OP_NOT, 1);
        emit_r(`OP_MOV, 3, 1);
        emit_r(`OP_OUT, 3);
        emit_ldm(4, -200);
        emit_r(`OP_IN, 5);
        emit_r(`OP_OUT, 4);
        emit_r(`OP_OUT, 5);

        // Shifts and carry, then taken and untaken jumps
        emit_ldm(1, $urandom_range(0, 511));
        emit_r(`OP_SHL, 1, 0, $urandom_range(0, 15));
        emit_r(`OP_OUT, 1);
        jump_over(`OP_JC, 1);
        emit_r(`OP_SHR, 1, 0, $urandom_range(0, 15));
        jump_over(`OP_JC, 1);
        emit_r(`OP_SETC);
        jump_over(`OP_JC, 1);
        emit_ldm(2, 0);
        emit_r(`OP_ADD, 2, 2);
        jump_over(`OP_JZ, 2);
        jump_over(`OP_JMP, 1);
        emit_ldm(2, 5);
        emit_r(`OP_OR, 2, 2);
        jump_over(`OP_JZ, 2);                  // Falls through

        for (k = 1; k <= 40; k++) begin
            op = 4'($urandom_range(0, 12));
            if (op == `OP_OUT)
                op = `OP_IN;
            if (op == `OP_LDM)
                emit_ldm($urandom_range(0, 7), $urandom_range(0, 511));
            else
                emit_r(op, $urandom_range(0, 7), $urandom_range(0, 7), $urandom_range(0, 15));
            if (k % 4 == 0)
                emit_r(`OP_OUT, $urandom_range(0, 7));
        end
        emit_ldm(7, prog.size() + 1);
        emit_r(`OP_JMP, 7);                    // Parks the core

        for (k = 0; k < 256; k++)
            imem[k] = (k < prog.size()) ? prog[k] : {8'h00, 8'(k)};   // NOP tagged with address
        run_model();
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        cycles = 0;
        while (exp_q.size() > 0 && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("Timed out with %0d expected outputs never seen", exp_q.size());
        end
        repeat (30) @(posedge clk);            // Room for stray strobes
        $display("Errors: %0d, outputs left unseen: %0d", errors, exp_q.size());
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module alu
    import cpu_pkg::*;
(
    input  logic [3:0]           opcode,
    input  logic [`CPU_XLEN-1:0] a,          // rd value
    input  logic [`CPU_XLEN-1:0] b,          // rs value
    input  logic [3:0]           shamt,
    input  logic [`CPU_XLEN-1:0] imm,
    input  logic [`CPU_XLEN-1:0] port_val,
    input  flags_t               flags_in,
    output logic [`CPU_XLEN-1:0] result,
    output flags_t               flags_out
);

    always_comb begin
        logic [`CPU_XLEN:0] wide;
        logic               set_nz;
        wide      = '0;
        set_nz    = 1'b0;
        result    = a;
        flags_out = flags_in;
        case (opcode)
            `OP_ADD: begin
                wide        = {1'b0, a} + {1'b0, b};
                result      = wide[`CPU_XLEN-1:0];
                flags_out.c = wide[`CPU_XLEN];
                set_nz      = 1'b1;
            end
            `OP_SUB: begin
                wide        = {1'b0, a} - {1'b0, b};
                result      = wide[`CPU_XLEN-1:0];
                flags_out.c = ~wide[`CPU_XLEN];   // Set when no borrow
                set_nz      = 1'b1;
            end
            `OP_AND: begin
                result = a & b;
                set_nz = 1'b1;
            end
            `OP_OR: begin
                result = a | b;
                set_nz = 1'b1;
            end
            `OP_NOT: begin
                result = ~a;
                set_nz = 1'b1;
            end
            `OP_SHL: begin
                wide   = {1'b0, a} << shamt;      // Top bit is last one out
                result = wide[`CPU_XLEN-1:0];
                if (shamt != 4'd0)
                    flags_out.c = wide[`CPU_XLEN];
                set_nz = 1'b1;
            end
            `OP_SHR: begin
                wide   = {a, 1'b0} >> shamt;      // Bit 0 is last one out
                result = wide[`CPU_XLEN:1];
                if (shamt != 4'd0)
                    flags_out.c = wide[0];
                set_nz = 1'b1;
            end
            `OP_MOV:  result = b;
            `OP_LDM:  result = imm;
            `OP_IN:   result = port_val;
            `OP_SETC: flags_out.c = 1'b1;
            default:  result = a;                 // NOP, OUT and jumps
        endcase
        if (set_nz) begin
            flags_out.n = result[`CPU_XLEN-1];
            flags_out.z = (result == '0);
        end
    end

    always_comb begin
        if (!$isunknown(opcode))
            a_result_known: assert (!$isunknown({result, flags_out}));
    end

endmodule

//--- verilog/branch_controller.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module branch_controller
    import cpu_pkg::*;
(
    input  logic [3:0] opcode,
    input  logic       valid,
    input  flags_t     flags,
    output logic       taken
);

    logic cond;

    always_comb begin
        case (opcode)
            `OP_JZ:  cond = flags.z;
            `OP_JC:  cond = flags.c;
            `OP_JMP: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign taken = valid && cond;   // Flushed slots never redirect

endmodule

//--- verilog/cpu_core.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_core
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    output logic [`CPU_XLEN-1:0] imem_addr,
    input  instr_t               imem_data,
    input  logic [`CPU_XLEN-1:0] in_port,
    output logic [`CPU_XLEN-1:0] out_port,
    output logic                 out_valid
);

    instr_t               if_instr;
    logic                 if_valid;
    id_ex_t               id_ex;
    ex_wb_t               wb;           // Also the register file write port
    logic                 jump_taken;
    logic [`CPU_XLEN-1:0] jump_target;

    fetch_stage u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .if_instr    (if_instr),
        .if_valid    (if_valid)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_instr (if_instr),
        .if_valid (if_valid),
        .flush    (jump_taken),
        .in_port  (in_port),
        .wb       (wb),
        .id_ex    (id_ex)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_ex       (id_ex),
        .wb          (wb),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .out_valid   (out_valid),
        .out_port    (out_port)
    );

endmodule

//--- verilog/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define CPU_XLEN     16
`define CPU_NREGS    8
`define CPU_PC_RESET 16'h0000

// Opcode field, bits [15:12] of every instruction
`define OP_NOP  4'd0
`define OP_ADD  4'd1
`define OP_SUB  4'd2
`define OP_AND  4'd3
`define OP_OR   4'd4
`define OP_NOT  4'd5
`define OP_SHL  4'd6
`define OP_SHR  4'd7
`define OP_MOV  4'd8
`define OP_LDM  4'd9
`define OP_SETC 4'd10
`define OP_OUT  4'd11
`define OP_IN   4'd12
`define OP_JZ   4'd13
`define OP_JC   4'd14
`define OP_JMP  4'd15

`endif

//--- verilog/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    // Register form: ALU ops, shifts, moves, ports, jumps
    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [3:0] shamt;
        logic [1:0] spare;
    } r_form_t;

    // Immediate form, LDM only
    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] rd;
        logic [8:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } instr_t;

    typedef struct packed {
        logic c;
        logic n;
        logic z;
    } flags_t;

    typedef struct packed {
        logic                 valid;
        logic [3:0]           opcode;
        logic [2:0]           rd;
        logic [2:0]           rs;
        logic [3:0]           shamt;
        logic [`CPU_XLEN-1:0] rd_val;
        logic [`CPU_XLEN-1:0] rs_val;
        logic [`CPU_XLEN-1:0] imm;      // Already sign extended
        logic [`CPU_XLEN-1:0] in_val;
        logic                 reg_write;
        logic                 flag_write;
    } id_ex_t;

    typedef struct packed {
        logic                 valid;
        logic                 reg_write;
        logic [2:0]           rd;
        logic [`CPU_XLEN-1:0] result;
        logic                 out_en;
        logic [`CPU_XLEN-1:0] out_val;
    } ex_wb_t;

endpackage

//--- verilog/decode_stage.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  instr_t               if_instr,
    input  logic                 if_valid,
    input  logic                 flush,
    input  logic [`CPU_XLEN-1:0] in_port,
    input  ex_wb_t               wb,
    output id_ex_t               id_ex
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];
    logic [3:0]           opcode;
    logic [2:0]           rd;
    logic [2:0]           rs;
    logic                 writes_reg;
    logic                 writes_flags;
    logic                 wb_en;
    id_ex_t               id_ex_d;

    assign opcode = if_instr.r_form.opcode;
    assign rd     = if_instr.r_form.rd;
    assign rs     = if_instr.r_form.rs;
    assign wb_en  = wb.valid && wb.reg_write;

    always_comb begin
        writes_reg   = 1'b0;
        writes_flags = 1'b0;
        case (opcode)
            `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_NOT, `OP_SHL, `OP_SHR: begin
                writes_reg   = 1'b1;
                writes_flags = 1'b1;
            end
            `OP_MOV, `OP_LDM, `OP_IN: writes_reg = 1'b1;
            `OP_SETC: writes_flags = 1'b1;
            `OP_NOP, `OP_OUT, `OP_JZ, `OP_JC, `OP_JMP: ;
        endcase
    end

    always_comb begin
        id_ex_d.valid      = if_valid && !flush;    // Jump shadow dies here
        id_ex_d.opcode     = opcode;
        id_ex_d.rd         = rd;
        id_ex_d.rs         = rs;
        id_ex_d.shamt      = if_instr.r_form.shamt;
        // Write-through from the write-back port
        id_ex_d.rd_val     = (wb_en && wb.rd == rd) ? wb.result : regs[rd];
        id_ex_d.rs_val     = (wb_en && wb.rd == rs) ? wb.result : regs[rs];
        id_ex_d.imm        = {{(`CPU_XLEN-9){if_instr.i_form.imm[8]}}, if_instr.i_form.imm};
        id_ex_d.in_val     = in_port;
        id_ex_d.reg_write  = id_ex_d.valid && writes_reg;
        id_ex_d.flag_write = id_ex_d.valid && writes_flags;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb.rd] <= wb.result;
        end
    end

    always_ff @(posedge clk) begin
        id_ex <= id_ex_d;
        if (!rst_n) begin
            id_ex.valid      <= 1'b0;
            id_ex.reg_write  <= 1'b0;
            id_ex.flag_write <= 1'b0;
        end
    end

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  id_ex_t               id_ex,
    output ex_wb_t               wb,
    output logic                 jump_taken,
    output logic [`CPU_XLEN-1:0] jump_target,
    output logic                 out_valid,
    output logic [`CPU_XLEN-1:0] out_port
);

    logic [`CPU_XLEN-1:0] op_rd;
    logic [`CPU_XLEN-1:0] op_rs;
    logic [`CPU_XLEN-1:0] alu_result;
    flags_t               alu_flags;
    flags_t               flags;
    ex_wb_t               wb_d;

    forwarding_unit u_fwd (
        .id_ex  (id_ex),
        .wb     (wb),
        .rd_val (op_rd),
        .rs_val (op_rs)
    );

    alu u_alu (
        .opcode    (id_ex.opcode),
        .a         (op_rd),
        .b         (op_rs),
        .shamt     (id_ex.shamt),
        .imm       (id_ex.imm),
        .port_val  (id_ex.in_val),
        .flags_in  (flags),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    // Uses the committed flags of older instructions
    branch_controller u_branch (
        .opcode (id_ex.opcode),
        .valid  (id_ex.valid),
        .flags  (flags),
        .taken  (jump_taken)
    );

    assign jump_target = op_rd;   // Register indirect

    always_ff @(posedge clk) begin
        if (!rst_n)
            flags <= '0;
        else if (id_ex.valid && id_ex.flag_write)
            flags <= alu_flags;
    end

    always_comb begin
        wb_d.valid     = id_ex.valid;
        wb_d.reg_write = id_ex.valid && id_ex.reg_write;
        wb_d.rd        = id_ex.rd;
        wb_d.result    = alu_result;
        wb_d.out_en    = id_ex.valid && (id_ex.opcode == `OP_OUT);
        wb_d.out_val   = op_rd;
    end

    always_ff @(posedge clk) begin
        wb <= wb_d;
        if (!rst_n) begin
            wb.valid     <= 1'b0;
            wb.reg_write <= 1'b0;
            wb.out_en    <= 1'b0;
        end
    end

    assign out_valid = wb.out_en;    // One-cycle strobe
    assign out_port  = wb.out_val;

    // Shadow slot behind a taken jump never executes
    a_jump_flush: assert property (@(posedge clk) disable iff (!rst_n)
        jump_taken |=> !id_ex.valid);

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module fetch_stage
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 jump_taken,
    input  logic [`CPU_XLEN-1:0] jump_target,
    input  instr_t               imem_data,
    output logic [`CPU_XLEN-1:0] imem_addr,
    output instr_t               if_instr,
    output logic                 if_valid
);

    logic [`CPU_XLEN-1:0] pc;

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= `CPU_PC_RESET;
            if_valid <= 1'b0;
        end else if (jump_taken) begin
            pc       <= jump_target;
            if_valid <= 1'b0;          // Kill the word fetched behind the jump
        end else begin
            pc       <= pc + 1'b1;
            if_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if_instr <= imem_data;
    end

    a_pc_known: assert property (@(posedge clk) rst_n |-> !$isunknown(imem_addr));

endmodule

//--- verilog/forwarding_unit.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module forwarding_unit
    import cpu_pkg::*;
(
    input  id_ex_t               id_ex,
    input  ex_wb_t               wb,
    output logic [`CPU_XLEN-1:0] rd_val,
    output logic [`CPU_XLEN-1:0] rs_val
);

    logic wb_live;
    logic hit_rd;
    logic hit_rs;

    // Only a real register write may override the decoded operand
    assign wb_live = wb.valid && wb.reg_write;
    assign hit_rd  = wb_live && (wb.rd == id_ex.rd);
    assign hit_rs  = wb_live && (wb.rd == id_ex.rs);

    assign rd_val = hit_rd ? wb.result : id_ex.rd_val;
    assign rs_val = hit_rs ? wb.result : id_ex.rs_val;

endmodule
